/* source/decode_pkg.sv */
// Decode package
// Instruction-level types for the RV32I decode stage: data words,
// register indices, the major opcodes kept by this core, ALU operations,
// operand and write-data selects, and the decoded control bundle that
// the instruction decoder hands to the rest of the stage
package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  // funct3 of a load or store, byte/half/word and signedness
  typedef logic [2:0]  mem_width_t;

  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic {
    SRC_A_RS1,
    SRC_A_PC
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS2,
    SRC_B_IMM_I,
    SRC_B_IMM_S,
    SRC_B_IMM_U
  } src_b_sel_t;

  typedef enum logic [1:0] {
    W_SRC_ALU,
    W_SRC_PC4,
    W_SRC_IMM_U
  } w_src_t;

  typedef struct packed {
    opcode_t    opcode;
    alu_op_t    alu_op;
    src_a_sel_t src_a;
    src_b_sel_t src_b;
    w_src_t     w_src;
    reg_addr_t  rd;
    logic       wen;
    logic       jump;
    logic       j_sel;     // JAL when set, JALR otherwise
    logic       arith;
    logic       load;
    logic       store;
    mem_width_t width;
    logic       illegal;
    logic       is_fence;
  } decoded_t;

endpackage

/* source/dispatch_pkg.sv */
// Dispatch package
// Issue-side types: the fetch packet entering decode, the functional
// unit classes, the fence sequencer states and the two issue packets
package dispatch_pkg;

  import decode_pkg::*;

  typedef enum logic {
    FU_ARITH,
    FU_LSU
  } fu_class_t;

  typedef struct packed {
    word_t  pc;
    instr_t instr;
  } fetch_packet_t;

  typedef enum logic [1:0] {
    FENCE_IDLE,
    FENCE_WAIT,
    FENCE_DONE
  } fence_state_t;

  // Arithmetic unit packet, also carries jumps and the illegal flag
  typedef struct packed {
    logic      valid;
    alu_op_t   alu_op;
    w_src_t    w_src;
    reg_addr_t rd;
    logic      wen;
    word_t     port_a;
    word_t     port_b;
    word_t     wdata;
    logic      jump;
    word_t     jump_base;
    word_t     jump_offset;
    logic      illegal;
    word_t     pc;
  } arith_issue_t;

  // Load/store unit packet, address is port_a plus port_b
  typedef struct packed {
    logic       valid;
    logic       load;
    logic       store;
    mem_width_t width;
    reg_addr_t  rd;
    logic       wen;
    word_t      port_a;
    word_t      port_b;
    word_t      store_data;
  } lsu_issue_t;

endpackage

/* source/instr_decoder.sv */
// Instruction decoder
// Maps an RV32I instruction word onto the decoded control bundle:
// unit class, ALU operation, operand selects, write source and enable,
// jump and memory flags. Opcodes outside the kept set decode as an
// arithmetic no-op flagged illegal
module instr_decoder
  import decode_pkg::*;
(
  input  instr_t    instr,
  output decoded_t  dec,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr
);

  logic [2:0] funct3;
  logic       bit30;
  reg_addr_t  rd;

  assign funct3   = instr[14:12];
  assign bit30    = instr[30];
  assign rd       = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // SUB only exists in register form, SRA in both
  function automatic alu_op_t alu_from_funct(logic [2:0] f3, logic b30, logic reg_op);
    alu_op_t op;
    case (f3)
      3'b000:  op = (reg_op && b30) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = b30 ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    dec        = '0;
    dec.opcode = OP_IMM;
    dec.alu_op = ALU_ADD;
    dec.src_a  = SRC_A_RS1;
    dec.src_b  = SRC_B_IMM_I;
    dec.w_src  = W_SRC_ALU;
    dec.rd     = rd;
    dec.wen    = 1'b1;
    dec.arith  = 1'b1;
    case (instr[6:0])
      OP: begin
        dec.opcode = OP;
        dec.alu_op = alu_from_funct(funct3, bit30, 1'b1);
        dec.src_b  = SRC_B_RS2;
      end
      OP_IMM: begin
        dec.alu_op = alu_from_funct(funct3, bit30, 1'b0);
      end
      LUI: begin
        dec.opcode = LUI;
        dec.src_b  = SRC_B_IMM_U;
        dec.w_src  = W_SRC_IMM_U;
      end
      AUIPC: begin
        dec.opcode = AUIPC;
        dec.src_a  = SRC_A_PC;
        dec.src_b  = SRC_B_IMM_U;
      end
      JAL: begin
        dec.opcode = JAL;
        dec.src_a  = SRC_A_PC;
        dec.w_src  = W_SRC_PC4;
        dec.jump   = 1'b1;
        dec.j_sel  = 1'b1;
      end
      JALR: begin
        dec.opcode = JALR;
        dec.w_src  = W_SRC_PC4;
        dec.jump   = 1'b1;
      end
      LOAD: begin
        dec.opcode = LOAD;
        dec.arith  = 1'b0;
        dec.load   = 1'b1;
        dec.width  = funct3;
      end
      STORE: begin
        dec.opcode = STORE;
        dec.src_b  = SRC_B_IMM_S;
        dec.arith  = 1'b0;
        dec.store  = 1'b1;
        dec.wen    = 1'b0;
        dec.width  = funct3;
      end
      MISC_MEM: begin
        dec.opcode   = MISC_MEM;
        dec.arith    = 1'b0;
        dec.is_fence = 1'b1;
      end
      default: begin
        dec.wen     = 1'b0;
        dec.illegal = 1'b1;
      end
    endcase
    // x0 is never written
    if (rd == '0) begin
      dec.wen = 1'b0;
    end
  end

  // Dispatch relies on each instruction naming exactly one destination
  always_comb begin
    if (!$isunknown(instr)) begin
      assert ($onehot({dec.arith, dec.load, dec.store, dec.is_fence}))
        else $error("instr_decoder: unit flags not one-hot for %h", instr);
    end
  end

endmodule

/* source/operand_select.sv */
// Operand select
// Sign-extends the I, S, U and J immediates, picks the two functional
// unit operands, the register write data and the jump base and offset
module operand_select
  import decode_pkg::*;
(
  input  instr_t   instr,
  input  decoded_t dec,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output word_t    port_a,
  output word_t    port_b,
  output word_t    wdata,
  output word_t    jump_base,
  output word_t    jump_offset,
  output word_t    store_data
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_j;
  word_t pc_plus4;

  assign imm_i    = {{20{instr[31]}}, instr[31:20]};
  assign imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u    = {instr[31:12], 12'b0};
  assign imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign pc_plus4 = pc + 32'd4;

  assign port_a     = (dec.src_a == SRC_A_PC) ? pc : rs1_data;
  assign store_data = rs2_data;

  always_comb begin
    case (dec.src_b)
      SRC_B_RS2:   port_b = rs2_data;
      SRC_B_IMM_I: port_b = imm_i;
      SRC_B_IMM_S: port_b = imm_s;
      default:     port_b = imm_u;
    endcase
  end

  // Link value for jumps, upper immediate for LUI
  always_comb begin
    case (dec.w_src)
      W_SRC_PC4:   wdata = pc_plus4;
      W_SRC_IMM_U: wdata = imm_u;
      default:     wdata = '0;
    endcase
  end

  always_comb begin
    if (!dec.jump) begin
      jump_base   = '0;
      jump_offset = '0;
    end else if (dec.j_sel) begin
      jump_base   = pc;
      jump_offset = imm_j;
    end else begin
      jump_base   = rs1_data;
      jump_offset = imm_i;
    end
  end

endmodule

/* source/fence_control.sv */
// Fence control
// Turns a FENCE into one flush request to both caches, holds decode
// until each cache has reported done once, then lets the fence retire
module fence_control
  import dispatch_pkg::*;
(
  input  logic CLK,
  input  logic nRST,
  input  logic fence_valid,
  input  logic icache_done,
  input  logic dcache_done,
  output logic flush_req,
  output logic fence_hold
);

  fence_state_t state;
  fence_state_t next_state;
  logic         i_seen;
  logic         d_seen;
  logic         i_got;
  logic         d_got;

  // Done pulses may arrive in either order and on different cycles
  assign i_got = i_seen | icache_done;
  assign d_got = d_seen | dcache_done;

  always_comb begin
    case (state)
      FENCE_IDLE: next_state = fence_valid ? FENCE_WAIT : FENCE_IDLE;
      FENCE_WAIT: next_state = (i_got && d_got) ? FENCE_DONE : FENCE_WAIT;
      default:    next_state = FENCE_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= FENCE_IDLE;
      i_seen <= 1'b0;
      d_seen <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        FENCE_IDLE: begin
          i_seen <= fence_valid & icache_done;
          d_seen <= fence_valid & dcache_done;
        end
        FENCE_WAIT: begin
          i_seen <= i_got;
          d_seen <= d_got;
        end
        default: begin
          i_seen <= 1'b0;
          d_seen <= 1'b0;
        end
      endcase
    end
  end

  assign flush_req  = (state == FENCE_IDLE) && fence_valid;
  // Released in FENCE_DONE so the fence leaves decode that cycle
  assign fence_hold = flush_req || (state == FENCE_WAIT);

  // Cache done pulses only answer an outstanding flush request
  assert property (@(posedge CLK) disable iff (!nRST)
    (icache_done || dcache_done) |-> fence_hold);

endmodule

/* source/dispatch_latch.sv */
// Dispatch latch
// Accepts one decoded instruction per cycle into the arithmetic or the
// load/store issue register, tagged with the completion buffer tail.
// Each register holds under its unit stall; flush empties both
module dispatch_latch
  import decode_pkg::*;
  import dispatch_pkg::*;
#(
  parameter int ROB_TAG_W = 4
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 in_valid,
  input  decoded_t             dec,
  input  word_t                pc,
  input  word_t                port_a,
  input  word_t                port_b,
  input  word_t                wdata,
  input  word_t                jump_base,
  input  word_t                jump_offset,
  input  word_t                store_data,
  input  logic                 fence_hold,
  input  logic [ROB_TAG_W-1:0] rob_tail,
  input  logic                 arith_stall,
  input  logic                 lsu_stall,
  input  logic                 flush,
  output logic                 in_ready,
  output logic                 rob_alloc,
  output arith_issue_t         arith_issue,
  output logic [ROB_TAG_W-1:0] arith_tag,
  output lsu_issue_t           lsu_issue,
  output logic [ROB_TAG_W-1:0] lsu_tag
);

  fu_class_t    target;
  logic         target_stall;
  logic         accept;
  logic         load_arith;
  logic         load_lsu;
  logic         arith_valid_q;
  logic         lsu_valid_q;
  arith_issue_t arith_next;
  arith_issue_t arith_q;
  lsu_issue_t   lsu_next;
  lsu_issue_t   lsu_q;

  assign target       = (dec.load || dec.store) ? FU_LSU : FU_ARITH;
  assign target_stall = (target == FU_LSU) ? lsu_stall : arith_stall;

  // A fence only waits on the caches, never on a unit stall
  assign in_ready   = !flush && !fence_hold && (dec.is_fence || !target_stall);
  assign accept     = in_valid && in_ready;
  assign rob_alloc  = accept && !dec.is_fence;
  assign load_arith = rob_alloc && (target == FU_ARITH);
  assign load_lsu   = rob_alloc && (target == FU_LSU);

  always_comb begin
    arith_next             = '0;
    arith_next.valid       = 1'b1;
    arith_next.alu_op      = dec.alu_op;
    arith_next.w_src       = dec.w_src;
    arith_next.rd          = dec.rd;
    arith_next.wen         = dec.wen;
    arith_next.port_a      = port_a;
    arith_next.port_b      = port_b;
    arith_next.wdata       = wdata;
    arith_next.jump        = dec.jump;
    arith_next.jump_base   = jump_base;
    arith_next.jump_offset = jump_offset;
    arith_next.illegal     = dec.illegal;
    arith_next.pc          = pc;
  end

  always_comb begin
    lsu_next            = '0;
    lsu_next.valid      = 1'b1;
    lsu_next.load       = dec.load;
    lsu_next.store      = dec.store;
    lsu_next.width      = dec.width;
    lsu_next.rd         = dec.rd;
    lsu_next.wen        = dec.wen;
    lsu_next.port_a     = port_a;
    lsu_next.port_b     = port_b;
    lsu_next.store_data = store_data;
  end

  // Flush wins over stall; an idle unit takes a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arith_valid_q <= 1'b0;
      lsu_valid_q   <= 1'b0;
    end else if (flush) begin
      arith_valid_q <= 1'b0;
      lsu_valid_q   <= 1'b0;
    end else begin
      if (!arith_stall) begin
        arith_valid_q <= load_arith;
      end
      if (!lsu_stall) begin
        lsu_valid_q <= load_lsu;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (load_arith) begin
      arith_q   <= arith_next;
      arith_tag <= rob_tail;
    end
    if (load_lsu) begin
      lsu_q   <= lsu_next;
      lsu_tag <= rob_tail;
    end
  end

  always_comb begin
    arith_issue       = arith_q;
    arith_issue.valid = arith_valid_q;
    lsu_issue         = lsu_q;
    lsu_issue.valid   = lsu_valid_q;
  end

  // Both units only hold work together when one of them was stalled
  assert property (@(posedge CLK) disable iff (!nRST)
    (arith_valid_q && lsu_valid_q) |-> $past(arith_stall || lsu_stall));

  assert property (@(posedge CLK) disable iff (!nRST)
    (arith_stall && !flush && arith_valid_q) |=> $stable(arith_issue) && $stable(arith_tag));

  assert property (@(posedge CLK) disable iff (!nRST)
    (lsu_stall && !flush && lsu_valid_q) |=> $stable(lsu_issue) && $stable(lsu_tag));

endmodule

/* source/decode_stage.sv */
// Decode stage
// Out-of-order RV32I decode: instruction decoder, operand selection,
// fence sequencing and the per-unit dispatch latch
module decode_stage
  import decode_pkg::*;
  import dispatch_pkg::*;
#(
  parameter int ROB_TAG_W = 4
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 in_valid,
  input  fetch_packet_t        in_pkt,
  output logic                 in_ready,
  output reg_addr_t            rs1_addr,
  output reg_addr_t            rs2_addr,
  input  word_t                rs1_data,
  input  word_t                rs2_data,
  input  logic [ROB_TAG_W-1:0] rob_tail,
  output logic                 rob_alloc,
  output arith_issue_t         arith_issue,
  output logic [ROB_TAG_W-1:0] arith_tag,
  output lsu_issue_t           lsu_issue,
  output logic [ROB_TAG_W-1:0] lsu_tag,
  input  logic                 arith_stall,
  input  logic                 lsu_stall,
  input  logic                 flush,
  output logic                 flush_req,
  input  logic                 icache_done,
  input  logic                 dcache_done
);

  decoded_t dec;
  word_t    port_a;
  word_t    port_b;
  word_t    wdata;
  word_t    jump_base;
  word_t    jump_offset;
  word_t    store_data;
  logic     fence_hold;

  instr_decoder decoder_i (
    .instr    (in_pkt.instr),
    .dec      (dec),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  operand_select opsel_i (
    .instr       (in_pkt.instr),
    .dec         (dec),
    .pc          (in_pkt.pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .port_a      (port_a),
    .port_b      (port_b),
    .wdata       (wdata),
    .jump_base   (jump_base),
    .jump_offset (jump_offset),
    .store_data  (store_data)
  );

  fence_control fence_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .fence_valid (in_valid && dec.is_fence),
    .icache_done (icache_done),
    .dcache_done (dcache_done),
    .flush_req   (flush_req),
    .fence_hold  (fence_hold)
  );

  dispatch_latch #(
    .ROB_TAG_W (ROB_TAG_W)
  ) latch_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_valid    (in_valid),
    .dec         (dec),
    .pc          (in_pkt.pc),
    .port_a      (port_a),
    .port_b      (port_b),
    .wdata       (wdata),
    .jump_base   (jump_base),
    .jump_offset (jump_offset),
    .store_data  (store_data),
    .fence_hold  (fence_hold),
    .rob_tail    (rob_tail),
    .arith_stall (arith_stall),
    .lsu_stall   (lsu_stall),
    .flush       (flush),
    .in_ready    (in_ready),
    .rob_alloc   (rob_alloc),
    .arith_issue (arith_issue),
    .arith_tag   (arith_tag),
    .lsu_issue   (lsu_issue),
    .lsu_tag     (lsu_tag)
  );

endmodule

/* bench/decode_stage_tb.sv */
// Decode stage testbench
// Drives random RV32I instructions and fences into the decode stage
// under random unit stalls and flushes. A register file, a completion
// buffer tail and a fence model run beside the DUT, and concurrent
// assertions compare issue packets, tags, ready and flush requests
module decode_stage_tb;

  import decode_pkg::*;
  import dispatch_pkg::*;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TAG_W = 4;
  localparam int unsigned WAIT_LIMIT = 100;
  localparam int RUN_OPS = 600;
  localparam word_t REG_SCALE = 32'h9e37_79b9;
  // Kept opcodes plus two that the stage does not support
  localparam logic [6:0] OPCODE_MIX [10] = '{
    OP, OP_IMM, LUI, AUIPC, JAL, JALR, LOAD, STORE, 7'b1110011, 7'b1100011
  };
  localparam alu_op_t ALU_BY_F3 [8] = '{
    ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
  };

  logic              CLK;
  logic              nRST;
  logic              in_valid;
  fetch_packet_t     in_pkt;
  logic              in_ready;
  reg_addr_t         rs1_addr;
  reg_addr_t         rs2_addr;
  word_t             rs1_data;
  word_t             rs2_data;
  logic [TAG_W-1:0]  tail = '0;
  logic              rob_alloc;
  arith_issue_t      arith_issue;
  logic [TAG_W-1:0]  arith_tag;
  lsu_issue_t        lsu_issue;
  logic [TAG_W-1:0]  lsu_tag;
  logic              arith_stall;
  logic              lsu_stall;
  logic              flush;
  logic              flush_req;
  logic              icache_done;
  logic              dcache_done;

  // Reference model state
  word_t             pc_next;
  arith_issue_t      exp_arith;
  lsu_issue_t        exp_lsu;
  logic              to_lsu;
  logic              is_fence;
  logic              accept;
  logic              accepted_q;
  logic              load_arith_q;
  logic              load_lsu_q;
  logic              bubble_arith_q;
  logic              bubble_lsu_q;
  logic              hold_arith_q;
  logic              hold_lsu_q;
  arith_issue_t      exp_arith_q;
  lsu_issue_t        exp_lsu_q;
  logic [TAG_W-1:0]  tag_q;
  arith_issue_t      arith_prev;
  lsu_issue_t        lsu_prev;
  logic [TAG_W-1:0]  arith_tag_prev;
  logic [TAG_W-1:0]  lsu_tag_prev;
  logic              fence_busy_q;
  logic              i_got_q;
  logic              d_got_q;

  decode_stage #(
    .ROB_TAG_W (TAG_W)
  ) dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_valid    (in_valid),
    .in_pkt      (in_pkt),
    .in_ready    (in_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rob_tail    (tail),
    .rob_alloc   (rob_alloc),
    .arith_issue (arith_issue),
    .arith_tag   (arith_tag),
    .lsu_issue   (lsu_issue),
    .lsu_tag     (lsu_tag),
    .arith_stall (arith_stall),
    .lsu_stall   (lsu_stall),
    .flush       (flush),
    .flush_req   (flush_req),
    .icache_done (icache_done),
    .dcache_done (dcache_done)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Register file contents, x0 reads zero
  function automatic word_t reg_value(input reg_addr_t addr);
    word_t scaled;
    scaled = word_t'(addr) * REG_SCALE;
    return (addr == '0) ? '0 : scaled;
  endfunction

  assign rs1_data = reg_value(rs1_addr);
  assign rs2_data = reg_value(rs2_addr);

  // Expected issue packets straight from the RV32I encoding
  function automatic void model_packet(input fetch_packet_t p, output arith_issue_t a,
                                       output lsu_issue_t l);
    logic [6:0] op;
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      rs1;
    word_t      rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      imm_j;
    logic       known;
    op    = p.instr[6:0];
    f3    = p.instr[14:12];
    rd    = p.instr[11:7];
    rs1   = reg_value(p.instr[19:15]);
    rs2   = reg_value(p.instr[24:20]);
    imm_i = {{20{p.instr[31]}}, p.instr[31:20]};
    imm_s = {{20{p.instr[31]}}, p.instr[31:25], p.instr[11:7]};
    imm_u = {p.instr[31:12], 12'h000};
    imm_j = {{12{p.instr[31]}}, p.instr[19:12], p.instr[20], p.instr[30:21], 1'b0};
    known = 1'b1;
    a        = '0;
    a.valid  = 1'b1;
    a.rd     = rd;
    a.pc     = p.pc;
    a.port_a = rs1;
    a.port_b = imm_i;
    a.alu_op = ALU_ADD;
    a.w_src  = W_SRC_ALU;
    case (op)
      OP, OP_IMM: begin
        a.alu_op = ALU_BY_F3[f3];
        if (op == OP) begin
          a.port_b = rs2;
        end
        if (f3 == 3'd0 && op == OP && p.instr[30]) begin
          a.alu_op = ALU_SUB;
        end
        if (f3 == 3'd5 && p.instr[30]) begin
          a.alu_op = ALU_SRA;
        end
      end
      LUI: begin
        a.port_b = imm_u;
        a.w_src  = W_SRC_IMM_U;
        a.wdata  = imm_u;
      end
      AUIPC: begin
        a.port_a = p.pc;
        a.port_b = imm_u;
      end
      JAL, JALR: begin
        a.w_src       = W_SRC_PC4;
        a.wdata       = p.pc + 32'd4;
        a.jump        = 1'b1;
        a.port_a      = (op == JAL) ? p.pc : rs1;
        a.jump_base   = (op == JAL) ? p.pc : rs1;
        a.jump_offset = (op == JAL) ? imm_j : imm_i;
      end
      LOAD, STORE, MISC_MEM: begin
        known = 1'b1;
      end
      default: begin
        known     = 1'b0;
        a.illegal = 1'b1;
      end
    endcase
    a.wen        = known && (op != STORE) && (rd != '0);
    l            = '0;
    l.valid      = 1'b1;
    l.load       = (op == LOAD);
    l.store      = (op == STORE);
    l.width      = f3;
    l.rd         = rd;
    l.wen        = (op == LOAD) && (rd != '0);
    l.port_a     = rs1;
    l.port_b     = (op == STORE) ? imm_s : imm_i;
    l.store_data = rs2;
  endfunction

  always_comb begin
    model_packet(in_pkt, exp_arith, exp_lsu);
  end

  assign to_lsu   = (in_pkt.instr[6:0] == LOAD) || (in_pkt.instr[6:0] == STORE);
  assign is_fence = (in_pkt.instr[6:0] == MISC_MEM);
  assign accept   = in_valid && in_ready;

  // Tail counter, acceptance history and fence progress
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      tail           <= '0;
      accepted_q     <= 1'b0;
      load_arith_q   <= 1'b0;
      load_lsu_q     <= 1'b0;
      bubble_arith_q <= 1'b0;
      bubble_lsu_q   <= 1'b0;
      hold_arith_q   <= 1'b0;
      hold_lsu_q     <= 1'b0;
      fence_busy_q   <= 1'b0;
      i_got_q        <= 1'b0;
      d_got_q        <= 1'b0;
    end else begin
      accepted_q     <= accept;
      load_arith_q   <= accept && !is_fence && !to_lsu;
      load_lsu_q     <= accept && to_lsu;
      bubble_arith_q <= flush || (!arith_stall && !(accept && !is_fence && !to_lsu));
      bubble_lsu_q   <= flush || (!lsu_stall && !(accept && to_lsu));
      hold_arith_q   <= arith_stall && !flush;
      hold_lsu_q     <= lsu_stall && !flush;
      exp_arith_q    <= exp_arith;
      exp_lsu_q      <= exp_lsu;
      tag_q          <= tail;
      arith_prev     <= arith_issue;
      lsu_prev       <= lsu_issue;
      arith_tag_prev <= arith_tag;
      lsu_tag_prev   <= lsu_tag;
      if (rob_alloc) begin
        tail <= tail + 1'b1;
      end
      if (accept && is_fence) begin
        fence_busy_q <= 1'b0;
        i_got_q      <= 1'b0;
        d_got_q      <= 1'b0;
      end else if (flush_req) begin
        fence_busy_q <= 1'b1;
        i_got_q      <= icache_done;
        d_got_q      <= dcache_done;
      end else if (fence_busy_q) begin
        i_got_q <= i_got_q || icache_done;
        d_got_q <= d_got_q || dcache_done;
      end
    end
  end

  task automatic stop_on_failure();
    $display("Errors found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [255:0] expected,
                                 input logic [255:0] actual);
    $display("Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_violation(input string what);
    $display("Error at %0t: %s", $time, what);
    stop_on_failure();
  endtask

  task automatic report_stuck(input string what);
    $display("Timeout at %0t: %s", $time, what);
    stop_on_failure();
  endtask

  assert property (@(posedge CLK) disable iff (!nRST) rob_alloc == (accept && !is_fence))
    else report_mismatch("rob_alloc", $sampled(accept) && !$sampled(is_fence),
                         $sampled(rob_alloc));
  assert property (@(posedge CLK) disable iff (!nRST) flush |-> !in_ready)
    else report_mismatch("in_ready", 1'b0, $sampled(in_ready));
  assert property (@(posedge CLK) disable iff (!nRST)
    (in_valid && !is_fence && (to_lsu ? lsu_stall : arith_stall)) |-> !in_ready)
    else report_mismatch("in_ready", 1'b0, $sampled(in_ready));
  assert property (@(posedge CLK) disable iff (!nRST)
    (in_valid && !is_fence && !flush && !(to_lsu ? lsu_stall : arith_stall)) |-> in_ready)
    else report_mismatch("in_ready", 1'b1, $sampled(in_ready));

  // Issue registers one edge after acceptance
  assert property (@(posedge CLK) disable iff (!nRST) load_arith_q |-> arith_issue == exp_arith_q)
    else report_mismatch("arith_issue", $sampled(exp_arith_q), $sampled(arith_issue));
  assert property (@(posedge CLK) disable iff (!nRST) load_arith_q |-> arith_tag == tag_q)
    else report_mismatch("arith_tag", $sampled(tag_q), $sampled(arith_tag));
  assert property (@(posedge CLK) disable iff (!nRST) load_lsu_q |-> lsu_issue == exp_lsu_q)
    else report_mismatch("lsu_issue", $sampled(exp_lsu_q), $sampled(lsu_issue));
  assert property (@(posedge CLK) disable iff (!nRST) load_lsu_q |-> lsu_tag == tag_q)
    else report_mismatch("lsu_tag", $sampled(tag_q), $sampled(lsu_tag));
  assert property (@(posedge CLK) disable iff (!nRST) bubble_arith_q |-> !arith_issue.valid)
    else report_mismatch("arith_issue.valid", 1'b0, $sampled(arith_issue.valid));
  assert property (@(posedge CLK) disable iff (!nRST) bubble_lsu_q |-> !lsu_issue.valid)
    else report_mismatch("lsu_issue.valid", 1'b0, $sampled(lsu_issue.valid));
  assert property (@(posedge CLK) disable iff (!nRST) hold_arith_q |-> arith_issue === arith_prev)
    else report_mismatch("arith_issue", $sampled(arith_prev), $sampled(arith_issue));
  assert property (@(posedge CLK) disable iff (!nRST) hold_lsu_q |-> lsu_issue === lsu_prev)
    else report_mismatch("lsu_issue", $sampled(lsu_prev), $sampled(lsu_issue));
  assert property (@(posedge CLK) disable iff (!nRST)
    hold_arith_q |-> arith_tag === arith_tag_prev)
    else report_mismatch("arith_tag", $sampled(arith_tag_prev), $sampled(arith_tag));
  assert property (@(posedge CLK) disable iff (!nRST)
    hold_lsu_q |-> lsu_tag === lsu_tag_prev)
    else report_mismatch("lsu_tag", $sampled(lsu_tag_prev), $sampled(lsu_tag));

  // One flush request per fence, retire only after both caches are done
  assert property (@(posedge CLK) disable iff (!nRST)
    flush_req |-> in_valid && is_fence && !fence_busy_q)
    else report_mismatch("flush_req", 1'b0, $sampled(flush_req));
  assert property (@(posedge CLK) disable iff (!nRST)
    (in_valid && is_fence && !fence_busy_q) |-> flush_req)
    else report_mismatch("flush_req", 1'b1, $sampled(flush_req));
  assert property (@(posedge CLK) disable iff (!nRST)
    (accept && is_fence) |-> fence_busy_q && i_got_q && d_got_q)
    else report_violation("fence accepted before both cache done pulses");
  assert property (@(posedge CLK) disable iff (!nRST)
    (in_valid && is_fence && fence_busy_q && i_got_q && d_got_q && !flush) |-> in_ready)
    else report_mismatch("in_ready", 1'b1, $sampled(in_ready));

  task automatic randomize_ctrl(input logic allow_flush);
    arith_stall = ($urandom % 4) == 0;
    lsu_stall   = ($urandom % 4) == 0;
    flush       = allow_flush && (($urandom % 20) == 0);
  endtask

  task automatic present(input instr_t word);
    in_pkt.pc    = pc_next;
    in_pkt.instr = word;
    in_valid     = 1'b1;
    pc_next      = pc_next + 32'd4;
  endtask

  task automatic wait_accept(input string what, input logic allow_flush);
    int unsigned waited;
    waited = 0;
    do begin
      @(posedge CLK);
      #1;
      waited++;
      randomize_ctrl(allow_flush);
    end while (!accepted_q && waited < WAIT_LIMIT);
    if (!accepted_q) begin
      report_stuck(what);
    end
  endtask

  function automatic instr_t make_instr();
    instr_t word;
    word      = $urandom();
    word[6:0] = OPCODE_MIX[$urandom % 10];
    return word;
  endfunction

  task automatic send_fence();
    instr_t      word;
    int unsigned waited;
    int unsigned i_delay;
    int unsigned d_delay;
    int unsigned last;
    word      = $urandom();
    word[6:0] = MISC_MEM;
    randomize_ctrl(1'b0);
    present(word);
    waited = 0;
    do begin
      @(posedge CLK);
      #1;
      waited++;
    end while (!fence_busy_q && waited < WAIT_LIMIT);
    if (!fence_busy_q) begin
      report_stuck("fence raised no cache flush request");
    end
    // Done pulses in random order, sometimes together
    i_delay = 1 + $urandom % 6;
    d_delay = 1 + $urandom % 6;
    last    = (i_delay > d_delay) ? i_delay : d_delay;
    for (int unsigned c = 1; c <= last; c++) begin
      icache_done = (c == i_delay);
      dcache_done = (c == d_delay);
      randomize_ctrl(1'b0);
      @(posedge CLK);
      #1;
    end
    icache_done = 1'b0;
    dcache_done = 1'b0;
    wait_accept("fence not accepted after both caches finished", 1'b0);
  endtask

  initial begin
    void'($urandom(32'hc136_a6da));
    nRST        = 1'b0;
    in_valid    = 1'b0;
    in_pkt      = '0;
    arith_stall = 1'b0;
    lsu_stall   = 1'b0;
    flush       = 1'b0;
    icache_done = 1'b0;
    dcache_done = 1'b0;
    pc_next     = $urandom() & 32'hffff_fffc;
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;
    for (int k = 0; k < RUN_OPS; k++) begin
      if ($urandom % 16 == 0) begin
        send_fence();
      end else begin
        present(make_instr());
        wait_accept("instruction held back past the timeout", 1'b1);
      end
      if ($urandom % 4 == 0) begin
        in_valid = 1'b0;
        @(posedge CLK);
        #1;
        randomize_ctrl(1'b1);
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

/* flist.f */
source/decode_pkg.sv
source/dispatch_pkg.sv
source/instr_decoder.sv
source/operand_select.sv
source/fence_control.sv
source/dispatch_latch.sv
source/decode_stage.sv
bench/decode_stage_tb.sv

/* Makefile */
# Verilator flow for the decode stage
TOP = decode_stage_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

# The simulator log decides pass or fail
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module decode_stage

clean:
	rm -rf obj_dir $(LOG)
